//--- project.f
mem_map_pkg.sv
req_pkg.sv
mem_chan_if.sv
rom_loader.sv
cpu_request_gen.sv
rv_bridge.sv
word_store.sv
mem_frontend_top.sv
tb_mem_frontend.sv

//--- tb_mem_frontend.sv
`timescale 1ns/1ps

module tb_mem_frontend;
    import mem_map_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int LOAD_BYTES  = 64;
    localparam int WRAM_OFFSET = (1 << BYTE_ADDR_W) - (1 << WRAM_ADDR_W);  // Top 8 KB
    localparam int RV_LIMIT    = 50;     // Cycles allowed for one soft-core access

    // Cycle budget per test, the watchdog allows twice the sum
    localparam int TEST_CYCLES = 20 + 300 + 400 + 400 + 150 + 300;

    logic                   mclk, resetn;
    logic                   loading, loader_valid, loaded;
    logic [7:0]             loader_data;
    byte_addr_t             rom_addr, rv_addr;
    logic                   rom_ce_n, rom_word;
    logic [15:0]            rom_q;
    logic [WRAM_ADDR_W-1:0] wram_addr;
    logic                   wram_ce_n, wram_rd_n, wram_we_n;
    logic [7:0]             wram_d, wram_q;
    logic                   rv_valid, rv_ready;
    logic [31:0]            rv_wdata, rv_rdata;
    logic [3:0]             rv_wstrb;

    logic [7:0] ref_mem [0:(1 << BYTE_ADDR_W) - 1];   // Mirror of every write
    int         err_cnt;
    int unsigned seed_val;

    mem_frontend_top UUT (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .loader_data(loader_data), .loader_valid(loader_valid),
        .loaded(loaded),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word), .rom_q(rom_q),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d), .wram_q(wram_q),
        .rv_valid(rv_valid), .rv_wdata(rv_wdata), .rv_wstrb(rv_wstrb), .rv_addr(rv_addr),
        .rv_ready(rv_ready), .rv_rdata(rv_rdata)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAIL");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic rom_read_check(input int addr, input logic word_mode);
        logic [15:0] word;
        logic [15:0] exp;
        word = {ref_mem[addr | 1], ref_mem[addr & ~1]};   // Odd byte in the high lane
        exp  = (word_mode || addr[0] == 1'b0) ? word : {word[7:0], word[15:8]};
        rom_ce_n = 1'b0;
        rom_word = word_mode;
        rom_addr = byte_addr_t'(addr);
        repeat (10) @(negedge mclk);
        check_value("rom_q", 32'(rom_q), 32'(exp));
    endtask

    task automatic wram_write(input int addr, input logic [7:0] data);
        ref_mem[WRAM_OFFSET + addr] = data;
        wram_addr = addr[WRAM_ADDR_W-1:0];
        wram_d    = data;
        wram_ce_n = 1'b0;
        wram_we_n = 1'b0;
        repeat (6) @(negedge mclk);
        wram_we_n = 1'b1;
        wram_ce_n = 1'b1;
        repeat (2) @(negedge mclk);
    endtask

    task automatic wram_read_check(input int addr);
        wram_addr = addr[WRAM_ADDR_W-1:0];
        wram_ce_n = 1'b0;
        wram_rd_n = 1'b0;
        repeat (10) @(negedge mclk);
        check_value("wram_q", 32'(wram_q), 32'(ref_mem[WRAM_OFFSET + addr]));
        wram_rd_n = 1'b1;
        wram_ce_n = 1'b1;
        @(negedge mclk);
    endtask

    // One soft-core access, waits for the ready pulse
    task automatic rv_access(input int addr, input logic [31:0] wdata, input logic [3:0] strb,
                             output logic [31:0] rdata);
        int cycles;
        cycles   = 0;
        rv_addr  = byte_addr_t'(addr);
        rv_wdata = wdata;
        rv_wstrb = strb;
        rv_valid = 1'b1;
        @(negedge mclk);
        while (rv_ready !== 1'b1) begin
            if (cycles >= RV_LIMIT) begin
                $display("Soft-core access at %h got no rv_ready", addr);
                $display("TEST FAIL");
                $fatal(1);
            end
            @(negedge mclk);
            cycles++;
        end
        rdata    = rv_rdata;
        rv_valid = 1'b0;
        @(negedge mclk);
    endtask

    task automatic rv_write(input int addr, input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] unused;
        for (int i = 0; i < 4; i++)
            if (strb[i]) ref_mem[addr + i] = data[8*i +: 8];
        rv_access(addr, data, strb, unused);
    endtask

    task automatic rv_read_check(input int addr);
        logic [31:0] got;
        logic [31:0] exp;
        exp = {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], ref_mem[addr]};
        rv_access(addr, 32'h0, 4'b0000, got);
        check_value("rv_rdata", got, exp);
    endtask

    task automatic test_reset();
        check_value("rv_ready", 32'(rv_ready), 32'h0);
        check_value("loaded", 32'(loaded), 32'h0);
    endtask

    task automatic test_rom_load();
        loading = 1'b1;
        @(negedge mclk);
        check_value("loaded", 32'(loaded), 32'h0);
        for (int i = 0; i < LOAD_BYTES; i++) begin
            ref_mem[i]   = 8'($urandom);
            loader_data  = ref_mem[i];
            loader_valid = 1'b1;
            @(negedge mclk);
            loader_valid = 1'b0;
            repeat (3) @(negedge mclk);   // Room for the store to keep up
        end
        repeat (10) @(negedge mclk);
        loading = 1'b0;
        repeat (2) @(negedge mclk);
        check_value("loaded", 32'(loaded), 32'h1);
    endtask

    task automatic test_wram();
        int addrs [4];
        addrs = '{32'h0010, 32'h0011, 32'h1ff7, 32'h0a42};
        rom_ce_n = 1'b1;
        foreach (addrs[i])
            wram_write(addrs[i], 8'($urandom));
        foreach (addrs[i])
            wram_read_check(addrs[i]);
        rom_read_check(16, 1'b1);   // Same low address bits as WRAM 0x10 and 0x11
    endtask

    task automatic test_rv_partial();
        logic [3:0] strbs [6];
        strbs = '{4'b0011, 4'b1100, 4'b0100, 4'b0010, 4'b1000, 4'b0001};
        rv_write(32'h4010, $urandom, 4'b1111);
        foreach (strbs[i]) begin
            rv_write(32'h4010, $urandom, strbs[i]);
            rv_read_check(32'h4010);
        end
    endtask

    initial begin
        resetn       = 1'b0;
        loading      = 1'b0;
        loader_data  = 8'h00;
        loader_valid = 1'b0;
        rom_addr     = '0;
        rom_ce_n     = 1'b1;
        rom_word     = 1'b1;
        wram_addr    = '0;
        wram_ce_n    = 1'b1;
        wram_rd_n    = 1'b1;
        wram_we_n    = 1'b1;
        wram_d       = 8'h00;
        rv_valid     = 1'b0;
        rv_wdata     = 32'h0;
        rv_wstrb     = 4'h0;
        rv_addr      = '0;
        err_cnt      = 0;
        seed_val     = $urandom(32'h9ff2);
        repeat (5) @(negedge mclk);
        resetn = 1'b1;
        @(negedge mclk);

        test_reset();
        test_rom_load();
        for (int a = 0; a < LOAD_BYTES; a += 2)
            rom_read_check(a, 1'b1);
        for (int a = 1; a < LOAD_BYTES; a += 2)
            rom_read_check(a, 1'b0);   // Byte mode, swapped word
        test_wram();
        rv_write(32'h4000, $urandom, 4'b1111);
        rv_read_check(32'h4000);
        rv_read_check(32'h0000);
        rv_read_check(32'h003c);
        test_rv_partial();

        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- mem_frontend_top.sv
`timescale 1ns/1ps

module mem_frontend_top (
    input  logic                                mclk,
    input  logic                                resetn,
    // Loader
    input  logic                                loading,
    input  logic [7:0]                          loader_data,
    input  logic                                loader_valid,
    output logic                                loaded,
    // ROM
    input  mem_map_pkg::byte_addr_t             rom_addr,
    input  logic                                rom_ce_n,
    input  logic                                rom_word,
    output logic [15:0]                         rom_q,
    // WRAM
    input  logic [mem_map_pkg::WRAM_ADDR_W-1:0] wram_addr,
    input  logic                                wram_ce_n,
    input  logic                                wram_rd_n,
    input  logic                                wram_we_n,
    input  logic [7:0]                          wram_d,
    output logic [7:0]                          wram_q,
    // Soft-core
    input  logic                                rv_valid,
    input  logic [31:0]                         rv_wdata,
    input  logic [3:0]                          rv_wstrb,
    input  mem_map_pkg::byte_addr_t             rv_addr,
    output logic                                rv_ready,
    output logic [31:0]                         rv_rdata
);
    import mem_map_pkg::*;

    logic        load_wr;
    word_addr_t  load_addr;
    logic [15:0] load_data;

    mem_chan_if cpu_chan ();
    mem_chan_if rv_chan ();

    rom_loader u_rom_loader (
        .mclk, .resetn, .loading, .loader_data, .loader_valid,
        .load_wr, .load_addr, .load_data, .loaded
    );

    cpu_request_gen u_cpu_request_gen (
        .mclk, .resetn, .loading, .load_wr, .load_addr, .load_data,
        .rom_addr, .rom_ce_n, .rom_word,
        .wram_addr, .wram_ce_n, .wram_rd_n, .wram_we_n, .wram_d,
        .rom_q, .wram_q, .cpu_chan(cpu_chan.requester)
    );

    rv_bridge u_rv_bridge (
        .mclk, .resetn, .rv_valid, .rv_addr, .rv_wdata, .rv_wstrb,
        .rv_ready, .rv_rdata, .rv_chan(rv_chan.requester)
    );

    word_store u_word_store (
        .mclk, .resetn, .cpu_chan(cpu_chan.store), .rv_chan(rv_chan.store)
    );

endmodule

//--- word_store.sv
`timescale 1ns/1ps

module word_store (
    input  logic      mclk,
    input  logic      resetn,
    mem_chan_if.store cpu_chan,
    mem_chan_if.store rv_chan
);
    import mem_map_pkg::*;
    import req_pkg::*;

    logic [15:0] mem [STORE_WORDS];

    logic        busy;
    logic        sel;           // 1 when serving rv_chan
    svc_cnt_t    cnt;
    logic        cpu_pend, rv_pend, grant_cpu, fin;
    word_addr_t  m_addr;
    logic [15:0] m_wdata;
    lane_t       m_lane;
    logic        m_we;

    assign cpu_pend  = cpu_chan.req != cpu_chan.ack;
    assign rv_pend   = rv_chan.req != rv_chan.ack;
    assign grant_cpu = ~busy & cpu_pend;     // cpu wins a tie
    assign fin       = busy && cnt == '0;

    assign m_addr  = sel ? rv_chan.addr  : cpu_chan.addr;
    assign m_wdata = sel ? rv_chan.wdata : cpu_chan.wdata;
    assign m_lane  = sel ? rv_chan.lane  : cpu_chan.lane;
    assign m_we    = sel ? rv_chan.we    : cpu_chan.we;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            busy         <= 1'b0;
            sel          <= 1'b0;
            cnt          <= '0;
            cpu_chan.ack <= 1'b0;
            rv_chan.ack  <= 1'b0;
        end else if (!busy) begin
            if (cpu_pend || rv_pend) begin
                busy <= 1'b1;
                sel  <= ~cpu_pend;
                cnt  <= svc_cnt_t'(SERVICE_CYCLES - 1);
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            busy <= 1'b0;
            if (sel) rv_chan.ack  <= rv_chan.req;
            else     cpu_chan.ack <= cpu_chan.req;
        end
    end

    // Access lands on the ack edge
    always_ff @(posedge mclk) begin
        if (fin && m_we) begin
            if (m_lane[0]) mem[m_addr][7:0]  <= m_wdata[7:0];
            if (m_lane[1]) mem[m_addr][15:8] <= m_wdata[15:8];
        end
        if (fin && !m_we) begin
            if (sel) rv_chan.rdata  <= mem[m_addr];
            else     cpu_chan.rdata <= mem[m_addr];
        end
    end

    a_cpu_ack_owned: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(cpu_chan.ack) |-> $past(cpu_pend));
    a_rv_ack_owned: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(rv_chan.ack) |-> $past(rv_pend));
    a_cpu_latency: assert property (@(posedge mclk) disable iff (!resetn)
        grant_cpu |=> ##SERVICE_CYCLES $changed(cpu_chan.ack));

endmodule

//--- rv_bridge.sv
`timescale 1ns/1ps

module rv_bridge (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    rv_valid,
    input  mem_map_pkg::byte_addr_t rv_addr,
    input  logic [31:0]             rv_wdata,
    input  logic [3:0]              rv_wstrb,
    output logic                    rv_ready,
    output logic [31:0]             rv_rdata,
    mem_chan_if.requester           rv_chan
);
    import mem_map_pkg::*;
    import req_pkg::*;

    bridge_state_t state;
    logic          rv_valid_r;
    logic          new_req;         // Request seen mid-access
    logic          start;
    logic          is_write;
    logic          chan_done;
    logic [15:0]   low_half;
    word_addr_t    lo_word_addr;
    word_addr_t    hi_word_addr;

    assign start        = rv_valid & ~rv_valid_r;
    assign is_write     = rv_wstrb != 4'b0;
    assign chan_done    = rv_chan.req == rv_chan.ack;
    assign lo_word_addr = {rv_addr[BYTE_ADDR_W-1:2], 1'b0};
    assign hi_word_addr = {rv_addr[BYTE_ADDR_W-1:2], 1'b1};
    assign rv_rdata     = {rv_chan.rdata, low_half};

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state       <= idle_req0;
            rv_ready    <= 1'b0;
            rv_valid_r  <= 1'b0;
            new_req     <= 1'b0;
            rv_chan.req <= 1'b0;
        end else begin
            rv_valid_r <= rv_valid;
            rv_ready   <= 1'b0;
            if (start)
                new_req <= 1'b1;

            case (state)
                idle_req0: if (new_req || start) begin
                    new_req     <= 1'b0;
                    rv_chan.req <= ~rv_chan.req;
                    rv_chan.we  <= is_write;
                    if (is_write && rv_wstrb[1:0] == 2'b00) begin
                        rv_chan.addr  <= hi_word_addr;     // Upper half only
                        rv_chan.wdata <= rv_wdata[31:16];
                        rv_chan.lane  <= rv_wstrb[3:2];
                        state         <= wait1;
                    end else begin
                        rv_chan.addr  <= lo_word_addr;
                        rv_chan.wdata <= rv_wdata[15:0];
                        rv_chan.lane  <= is_write ? rv_wstrb[1:0] : 2'b11;
                        state         <= wait0_req1;
                    end
                end

                wait0_req1: if (chan_done) begin
                    if (!is_write) begin
                        state <= data0;
                    end else if (rv_wstrb[3:2] == 2'b00) begin
                        rv_ready <= 1'b1;                  // Lower half only
                        state    <= idle_req0;
                    end else begin
                        rv_chan.req   <= ~rv_chan.req;
                        rv_chan.addr  <= hi_word_addr;
                        rv_chan.wdata <= rv_wdata[31:16];
                        rv_chan.lane  <= rv_wstrb[3:2];
                        state         <= wait1;
                    end
                end

                data0: begin
                    low_half      <= rv_chan.rdata;        // Still valid, no new req yet
                    rv_chan.req   <= ~rv_chan.req;
                    rv_chan.addr  <= hi_word_addr;
                    rv_chan.lane  <= 2'b11;
                    state         <= wait1;
                end

                wait1: if (chan_done) begin
                    if (is_write) begin
                        rv_ready <= 1'b1;
                        state    <= idle_req0;
                    end else begin
                        state <= data1;
                    end
                end

                data1: begin
                    rv_ready <= 1'b1;
                    state    <= idle_req0;
                end

                default: state <= idle_req0;
            endcase
        end
    end

    a_ready_pulse: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |=> !rv_ready);

endmodule

//--- cpu_request_gen.sv
`timescale 1ns/1ps

module cpu_request_gen (
    input  logic                                mclk,
    input  logic                                resetn,
    input  logic                                loading,
    input  logic                                load_wr,
    input  mem_map_pkg::word_addr_t             load_addr,
    input  logic [15:0]                         load_data,
    input  mem_map_pkg::byte_addr_t             rom_addr,
    input  logic                                rom_ce_n,
    input  logic                                rom_word,
    input  logic [mem_map_pkg::WRAM_ADDR_W-1:0] wram_addr,
    input  logic                                wram_ce_n,
    input  logic                                wram_rd_n,
    input  logic                                wram_we_n,
    input  logic [7:0]                          wram_d,
    output logic [15:0]                         rom_q,
    output logic [7:0]                          wram_q,
    mem_chan_if.requester                       cpu_chan
);
    import mem_map_pkg::*;

    logic busy, wram_rd, wram_wr, wram_rd_r, wram_wr_r, wram_edge, wram_edge_pend;
    logic load_pend, load_trig, wram_trig, rom_trig;
    word_addr_t load_pend_addr;
    logic [15:0] load_pend_data;
    word_addr_t rom_sent;
    logic rom_sent_ok;                  // rom_sent holds a valid address
    logic [WRAM_ADDR_W-2:0] wram_sent;
    logic rd_pending, rd_port;          // Port 1 is WRAM
    logic [15:0] rom_word_r, wram_word_r;

    assign busy      = cpu_chan.req != cpu_chan.ack;
    assign wram_rd   = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr   = ~wram_ce_n & ~wram_we_n;
    assign wram_edge = (wram_rd & ~wram_rd_r) | (wram_wr & ~wram_wr_r);
    assign load_trig = load_pend | load_wr;
    assign wram_trig = wram_edge_pend | wram_edge
                     | (wram_rd & (wram_addr[WRAM_ADDR_W-1:1] != wram_sent));
    assign rom_trig  = ~rom_ce_n & ~loading
                     & (~rom_sent_ok | (rom_addr[BYTE_ADDR_W-1:1] != rom_sent));

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_chan.req   <= 1'b0;
            wram_rd_r      <= 1'b0;
            wram_wr_r      <= 1'b0;
            wram_edge_pend <= 1'b0;
            load_pend      <= 1'b0;
            rom_sent_ok    <= 1'b0;
            rd_pending     <= 1'b0;
            rd_port        <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (load_wr) begin
                load_pend      <= 1'b1;
                load_pend_addr <= load_addr;
                load_pend_data <= load_data;
            end
            if (wram_edge)
                wram_edge_pend <= 1'b1;
            if (loading)
                rom_sent_ok <= 1'b0;

            // Result of the last read, before any new request replaces it
            if (!busy && rd_pending) begin
                rd_pending <= 1'b0;
                if (rd_port) wram_word_r <= cpu_chan.rdata;
                else         rom_word_r  <= cpu_chan.rdata;
            end

            if (!busy) begin
                if (load_trig) begin
                    cpu_chan.req   <= ~cpu_chan.req;
                    cpu_chan.addr  <= load_pend ? load_pend_addr : load_addr;
                    cpu_chan.wdata <= load_pend ? load_pend_data : load_data;
                    cpu_chan.lane  <= 2'b11;
                    cpu_chan.we    <= 1'b1;
                    load_pend      <= load_pend & load_wr;   // Keep a newer word
                end else if (wram_trig) begin
                    cpu_chan.req   <= ~cpu_chan.req;
                    cpu_chan.addr  <= {WRAM_BASE_HI, wram_addr[WRAM_ADDR_W-1:1]};
                    cpu_chan.wdata <= {wram_d, wram_d};
                    cpu_chan.lane  <= {wram_addr[0], ~wram_addr[0]};
                    cpu_chan.we    <= wram_wr;
                    wram_sent      <= wram_addr[WRAM_ADDR_W-1:1];
                    wram_edge_pend <= 1'b0;
                    rd_pending     <= ~wram_wr;
                    rd_port        <= 1'b1;
                end else if (rom_trig) begin
                    cpu_chan.req   <= ~cpu_chan.req;
                    cpu_chan.addr  <= rom_addr[BYTE_ADDR_W-1:1];
                    cpu_chan.lane  <= 2'b11;
                    cpu_chan.we    <= 1'b0;
                    rom_sent       <= rom_addr[BYTE_ADDR_W-1:1];
                    rom_sent_ok    <= 1'b1;
                    rd_pending     <= 1'b1;
                    rd_port        <= 1'b0;
                end
            end
        end
    end

    assign rom_q  = (rom_word || ~rom_addr[0]) ? rom_word_r
                                                : {rom_word_r[7:0], rom_word_r[15:8]};
    assign wram_q = wram_addr[0] ? wram_word_r[15:8] : wram_word_r[7:0];

    // Fields must hold while the store works on them
    a_one_outstanding: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(cpu_chan.req) |-> $past(cpu_chan.req == cpu_chan.ack));

endmodule

//--- rom_loader.sv
`timescale 1ns/1ps

module rom_loader (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    loading,
    input  logic [7:0]              loader_data,
    input  logic                    loader_valid,
    output logic                    load_wr,
    output mem_map_pkg::word_addr_t load_addr,
    output logic [15:0]             load_data,
    output logic                    loaded
);
    import mem_map_pkg::*;

    byte_addr_t byte_cnt;
    byte_addr_t cnt_now;
    logic       loading_r;
    logic       take;
    logic [7:0] low_byte;

    // A new load restarts the count at byte 0
    assign cnt_now = (loading & ~loading_r) ? '0 : byte_cnt;
    assign take    = loading & loader_valid;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            loaded    <= 1'b0;
            byte_cnt  <= '0;
            load_wr   <= 1'b0;
        end else begin
            loading_r <= loading;
            byte_cnt  <= cnt_now + byte_addr_t'(take);
            load_wr   <= take & cnt_now[0];   // One word per odd byte
            if (loading & ~loading_r)
                loaded <= 1'b0;
            if (~loading & loading_r)
                loaded <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (take & ~cnt_now[0])
            low_byte <= loader_data;
        if (take & cnt_now[0]) begin
            load_data <= {loader_data, low_byte};
            load_addr <= cnt_now[BYTE_ADDR_W-1:1];
        end
    end

    a_wr_in_load: assert property (@(posedge mclk) disable iff (!resetn)
        load_wr |-> loading);

endmodule

//--- mem_chan_if.sv
`timescale 1ns/1ps

interface mem_chan_if;
    import mem_map_pkg::*;
    import req_pkg::*;

    word_addr_t  addr;
    logic [15:0] wdata;
    lane_t       lane;
    logic        we;
    logic        req;       // Toggles once per access
    logic [15:0] rdata;
    logic        ack;       // Follows req when the access is done

    modport requester (
        output addr, wdata, lane, we, req,
        input  rdata, ack
    );

    modport store (
        input  addr, wdata, lane, we, req,
        output rdata, ack
    );

endinterface

//--- req_pkg.sv
package req_pkg;

    // Byte-lane strobe, bit 1 is the high byte
    typedef logic [1:0] lane_t;

    // Soft-core bridge sequence for one 32-bit access
    typedef enum logic [2:0] {
        idle_req0,
        wait0_req1,
        data0,
        wait1,
        data1
    } bridge_state_t;

    // Cycles from grant to ack in the word store
    localparam int SERVICE_CYCLES = 2;

    typedef logic [$clog2(SERVICE_CYCLES + 1) - 1:0] svc_cnt_t;

endpackage

//--- mem_map_pkg.sv
package mem_map_pkg;

    // Shared byte space seen by ROM, WRAM and the soft-core
    localparam int BYTE_ADDR_W = 15;            // 32 KB
    localparam int WORD_ADDR_W = BYTE_ADDR_W - 1;

    // WRAM sits in the top 8 KB
    localparam int WRAM_ADDR_W = 13;
    localparam logic [BYTE_ADDR_W-WRAM_ADDR_W-1:0] WRAM_BASE_HI = '1;

    // One 16-bit word per word address
    localparam int STORE_WORDS = 1 << WORD_ADDR_W;

    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

endpackage
